// File: mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Data words and addresses share one width
`define MIPS_XLEN 32

// Register file geometry
`define MIPS_REG_AW 5
`define MIPS_NREGS 32

`define MIPS_RESET_PC 32'h0000_0000   // First fetch address

`endif

// File: mips_isa_pkg.sv
`default_nettype none

`include "mips_cfg.svh"

package mips_isa_pkg;

  typedef logic [`MIPS_XLEN-1:0]   word_t;
  typedef logic [`MIPS_REG_AW-1:0] reg_addr_t;
  typedef logic [5:0]              opcode_t;
  typedef logic [5:0]              funct_t;
  typedef logic [2:0]              alu_op_t;
  typedef logic [15:0]             imm_t;

  // Primary opcodes
  localparam opcode_t OP_RTYPE = 6'b000000;
  localparam opcode_t OP_LW    = 6'b100011;
  localparam opcode_t OP_SW    = 6'b101011;
  localparam opcode_t OP_BEQ   = 6'b000100;
  localparam opcode_t OP_BNE   = 6'b000101;
  localparam opcode_t OP_ADDI  = 6'b001000;
  localparam opcode_t OP_ADDIU = 6'b001001;

  // R-type function codes
  localparam funct_t FN_ADD  = 6'b100000;
  localparam funct_t FN_ADDU = 6'b100001;
  localparam funct_t FN_SUB  = 6'b100010;
  localparam funct_t FN_SUBU = 6'b100011;
  localparam funct_t FN_AND  = 6'b100100;
  localparam funct_t FN_OR   = 6'b100101;
  localparam funct_t FN_SLT  = 6'b101010;

  localparam alu_op_t ALU_AND = 3'b000;
  localparam alu_op_t ALU_OR  = 3'b001;
  localparam alu_op_t ALU_ADD = 3'b010;
  localparam alu_op_t ALU_SUB = 3'b110;
  localparam alu_op_t ALU_SLT = 3'b111;   // Signed compare

endpackage

`default_nettype wire

// File: mips_pipe_pkg.sv
`default_nettype none

package mips_pipe_pkg;
  import mips_isa_pkg::*;

  // One control bundle per stage that consumes it
  typedef struct packed {
    alu_op_t alu_op;
    logic    alu_src;     // Immediate as operand B
    logic    reg_dst;     // Write rd instead of rt
    logic    branch;
    logic    branch_ne;   // Taken when operands differ
    logic    mem_read;
  } ex_ctrl_t;

  typedef struct packed {
    logic mem_write;
  } mem_ctrl_t;

  typedef struct packed {
    logic reg_write;
    logic mem_to_reg;     // Load data instead of ALU result
  } wb_ctrl_t;

  // Operand source in execute
  typedef logic [1:0] fwd_sel_t;

  localparam fwd_sel_t FWD_NONE = 2'b00;
  localparam fwd_sel_t FWD_MEM  = 2'b01;
  localparam fwd_sel_t FWD_WB   = 2'b10;

  typedef struct packed {
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
  } fwd_t;

  //--------------------------------------------------------------------------
  // Data pipeline registers

  typedef struct packed {
    word_t pc_plus4;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    word_t     pc_plus4;
    word_t     rd1;
    word_t     rd2;
    word_t     sign_imm;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
  } id_ex_t;

  typedef struct packed {
    word_t     alu_out;
    word_t     write_data;
    reg_addr_t write_reg;
  } ex_mem_t;

  typedef struct packed {
    word_t     alu_out;
    word_t     read_data;
    reg_addr_t write_reg;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: mips_control.sv
`timescale 1ns/100ps
`default_nettype none

module mips_control import mips_isa_pkg::*, mips_pipe_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  input  wire          flush_id_ex,
  input  wire opcode_t op,
  input  wire funct_t  funct,
  output ex_ctrl_t     ex_ctrl,
  output mem_ctrl_t    mem_ctrl,
  output wb_ctrl_t     wb_ctrl,
  output logic         ex_mem_read,
  output logic         mem_reg_write,
  output logic         wb_reg_write
);

  ex_ctrl_t  id_ex_ctrl;
  mem_ctrl_t id_mem_ctrl;
  wb_ctrl_t  id_wb_ctrl;
  alu_op_t   rtype_op;
  logic      funct_known;
  mem_ctrl_t ex_mem_ctrl;   // Travels with the instruction in execute
  wb_ctrl_t  ex_wb_ctrl;
  wb_ctrl_t  mem_wb_ctrl;

  // Function code of R-type instructions
  always_comb begin
    funct_known = 1'b1;
    case (funct)
      FN_ADD, FN_ADDU: rtype_op = ALU_ADD;   // No overflow trap
      FN_SUB, FN_SUBU: rtype_op = ALU_SUB;
      FN_AND:          rtype_op = ALU_AND;
      FN_OR:           rtype_op = ALU_OR;
      FN_SLT:          rtype_op = ALU_SLT;
      default: begin
        rtype_op    = ALU_AND;
        funct_known = 1'b0;
      end
    endcase
  end

  // Main decoder leaves all bundles at zero for unknown opcodes
  always_comb begin
    id_ex_ctrl  = '0;
    id_mem_ctrl = '0;
    id_wb_ctrl  = '0;
    case (op)
      OP_RTYPE: begin
        if (funct_known) begin
          id_ex_ctrl.alu_op    = rtype_op;
          id_ex_ctrl.reg_dst   = 1'b1;
          id_wb_ctrl.reg_write = 1'b1;
        end
      end
      OP_LW: begin
        id_ex_ctrl.alu_op     = ALU_ADD;
        id_ex_ctrl.alu_src    = 1'b1;
        id_ex_ctrl.mem_read   = 1'b1;
        id_wb_ctrl.reg_write  = 1'b1;
        id_wb_ctrl.mem_to_reg = 1'b1;
      end
      OP_SW: begin
        id_ex_ctrl.alu_op     = ALU_ADD;
        id_ex_ctrl.alu_src    = 1'b1;
        id_mem_ctrl.mem_write = 1'b1;
      end
      OP_BEQ, OP_BNE: begin
        id_ex_ctrl.alu_op    = ALU_SUB;   // Equality via zero flag
        id_ex_ctrl.branch    = 1'b1;
        id_ex_ctrl.branch_ne = (op == OP_BNE);
      end
      OP_ADDI, OP_ADDIU: begin
        id_ex_ctrl.alu_op    = ALU_ADD;
        id_ex_ctrl.alu_src   = 1'b1;
        id_wb_ctrl.reg_write = 1'b1;
      end
      default: ;
    endcase
  end

  //--------------------------------------------------------------------------
  // Control pipeline

  always_ff @(posedge clk) begin
    if (!rst_n || flush_id_ex) begin
      ex_ctrl     <= '0;   // Bubble
      ex_mem_ctrl <= '0;
      ex_wb_ctrl  <= '0;
    end else begin
      ex_ctrl     <= id_ex_ctrl;
      ex_mem_ctrl <= id_mem_ctrl;
      ex_wb_ctrl  <= id_wb_ctrl;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_ctrl    <= '0;
      mem_wb_ctrl <= '0;
      wb_ctrl     <= '0;
    end else begin
      mem_ctrl    <= ex_mem_ctrl;
      mem_wb_ctrl <= ex_wb_ctrl;
      wb_ctrl     <= mem_wb_ctrl;
    end
  end

  assign ex_mem_read   = ex_ctrl.mem_read;
  assign mem_reg_write = mem_wb_ctrl.reg_write;
  assign wb_reg_write  = wb_ctrl.reg_write;

endmodule

`default_nettype wire

// File: hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit import mips_isa_pkg::*, mips_pipe_pkg::*; (
  input  wire reg_addr_t id_rs,
  input  wire reg_addr_t id_rt,
  input  wire reg_addr_t ex_rs,
  input  wire reg_addr_t ex_rt,
  input  wire reg_addr_t ex_write_reg,
  input  wire reg_addr_t mem_write_reg,
  input  wire reg_addr_t wb_write_reg,
  input  wire            ex_mem_read,
  input  wire            mem_reg_write,
  input  wire            wb_reg_write,
  input  wire            branch_taken,
  output fwd_t           fwd,
  output logic           stall,
  output logic           flush_if_id,
  output logic           flush_id_ex
);

  // Younger result in memory stage has priority
  function automatic fwd_sel_t pick_src(input reg_addr_t src);
    if (mem_reg_write && mem_write_reg != '0 && mem_write_reg == src) begin
      return FWD_MEM;
    end else if (wb_reg_write && wb_write_reg != '0 && wb_write_reg == src) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  always_comb begin
    fwd.fwd_a = pick_src(ex_rs);
    fwd.fwd_b = pick_src(ex_rt);
  end

  // Load result not ready for the instruction right behind it
  assign stall = ex_mem_read && (ex_write_reg != '0) &&
                 (ex_write_reg == id_rs || ex_write_reg == id_rt);

  assign flush_if_id = branch_taken;
  assign flush_id_ex = stall || branch_taken;   // Bubble into execute

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_cfg.svh"

module regfile import mips_isa_pkg::*; (
  input  wire            clk,
  input  wire            we,
  input  wire reg_addr_t ra1,
  input  wire reg_addr_t ra2,
  input  wire reg_addr_t wa,
  input  wire word_t     wd,
  output word_t          rd1,
  output word_t          rd2
);

  word_t regs [`MIPS_NREGS];

  always_ff @(posedge clk) begin
    if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  // Writeback data shows through in the same cycle
  assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import mips_isa_pkg::*; (
  input  wire word_t   a,
  input  wire word_t   b,
  input  wire alu_op_t op,
  output word_t        y,
  output logic         zero
);

  always_comb begin
    case (op)
      ALU_ADD: y = a + b;
      ALU_SUB: y = a - b;
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      ALU_SLT: y = word_t'($signed(a) < $signed(b));
      default: y = '0;
    endcase
  end

  assign zero = (y == '0);   // Branch compare result

endmodule

`default_nettype wire

// File: mips_datapath.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_cfg.svh"

module mips_datapath import mips_isa_pkg::*, mips_pipe_pkg::*; (
  input  wire            clk,
  input  wire            rst_n,
  input  wire            stall,
  input  wire            flush_if_id,
  input  wire ex_ctrl_t  ex_ctrl,
  input  wire mem_ctrl_t mem_ctrl,
  input  wire wb_ctrl_t  wb_ctrl,
  input  wire fwd_t      fwd,
  output opcode_t        op,
  output funct_t         funct,
  output reg_addr_t      id_rs,
  output reg_addr_t      id_rt,
  output reg_addr_t      ex_rs,
  output reg_addr_t      ex_rt,
  output reg_addr_t      ex_write_reg,
  output reg_addr_t      mem_write_reg,
  output reg_addr_t      wb_write_reg,
  output logic           branch_taken,
  output word_t          pc,
  input  wire word_t     instr,
  output logic           mem_write,
  output word_t          mem_addr,
  output word_t          mem_wdata,
  input  wire word_t     mem_rdata
);

  if_id_t    if_id_q;
  id_ex_t    id_ex_q;
  ex_mem_t   ex_mem_q;
  mem_wb_t   mem_wb_q;
  word_t     pc_plus4;
  imm_t      id_imm;
  reg_addr_t id_rd;
  word_t     id_sign_imm;
  word_t     id_rd1;
  word_t     id_rd2;
  word_t     ex_src_a;
  word_t     ex_fwd_b;      // Also the store data
  word_t     ex_src_b;
  word_t     ex_alu_out;
  word_t     ex_branch_target;
  logic      ex_zero;
  word_t     wb_result;

  //--------------------------------------------------------------------------
  // Fetch

  assign pc_plus4 = pc + word_t'(4);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `MIPS_RESET_PC;
    end else if (branch_taken) begin
      pc <= ex_branch_target;
    end else if (!stall) begin
      pc <= pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_if_id) begin
      if_id_q <= '0;
    end else if (!stall) begin   // Hold on load-use
      if_id_q.pc_plus4 <= pc_plus4;
      if_id_q.instr    <= instr;
    end
  end

  //--------------------------------------------------------------------------
  // Decode

  assign op          = if_id_q.instr[31:26];
  assign funct       = if_id_q.instr[5:0];
  assign id_rs       = if_id_q.instr[25:21];
  assign id_rt       = if_id_q.instr[20:16];
  assign id_rd       = if_id_q.instr[15:11];
  assign id_imm      = if_id_q.instr[15:0];
  assign id_sign_imm = {{(`MIPS_XLEN-16){id_imm[15]}}, id_imm};

  regfile i_regfile (
    .clk (clk),
    .we  (wb_ctrl.reg_write),
    .ra1 (id_rs),
    .ra2 (id_rt),
    .wa  (wb_write_reg),
    .wd  (wb_result),
    .rd1 (id_rd1),
    .rd2 (id_rd2)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex_q <= '0;
    end else begin
      id_ex_q.pc_plus4 <= if_id_q.pc_plus4;
      id_ex_q.rd1      <= id_rd1;
      id_ex_q.rd2      <= id_rd2;
      id_ex_q.sign_imm <= id_sign_imm;
      id_ex_q.rs       <= id_rs;
      id_ex_q.rt       <= id_rt;
      id_ex_q.rd       <= id_rd;
    end
  end

  //--------------------------------------------------------------------------
  // Execute

  function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                    input word_t mem_val, input word_t wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign ex_rs        = id_ex_q.rs;
  assign ex_rt        = id_ex_q.rt;
  assign ex_write_reg = ex_ctrl.reg_dst ? id_ex_q.rd : id_ex_q.rt;

  assign ex_src_a = fwd_mux(fwd.fwd_a, id_ex_q.rd1, ex_mem_q.alu_out, wb_result);
  assign ex_fwd_b = fwd_mux(fwd.fwd_b, id_ex_q.rd2, ex_mem_q.alu_out, wb_result);
  assign ex_src_b = ex_ctrl.alu_src ? id_ex_q.sign_imm : ex_fwd_b;

  alu i_alu (
    .a    (ex_src_a),
    .b    (ex_src_b),
    .op   (ex_ctrl.alu_op),
    .y    (ex_alu_out),
    .zero (ex_zero)
  );

  // Word offset relative to the delay-free pc+4
  assign ex_branch_target = id_ex_q.pc_plus4 + {id_ex_q.sign_imm[`MIPS_XLEN-3:0], 2'b00};
  assign branch_taken     = ex_ctrl.branch && (ex_zero != ex_ctrl.branch_ne);

  //--------------------------------------------------------------------------
  // Memory and writeback

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem_q <= '0;
      mem_wb_q <= '0;
    end else begin
      ex_mem_q.alu_out    <= ex_alu_out;
      ex_mem_q.write_data <= ex_fwd_b;
      ex_mem_q.write_reg  <= ex_write_reg;
      mem_wb_q.alu_out    <= ex_mem_q.alu_out;
      mem_wb_q.read_data  <= mem_rdata;
      mem_wb_q.write_reg  <= ex_mem_q.write_reg;
    end
  end

  assign mem_write     = mem_ctrl.mem_write;
  assign mem_addr      = ex_mem_q.alu_out;
  assign mem_wdata     = ex_mem_q.write_data;
  assign mem_write_reg = ex_mem_q.write_reg;

  assign wb_write_reg = mem_wb_q.write_reg;
  assign wb_result    = wb_ctrl.mem_to_reg ? mem_wb_q.read_data : mem_wb_q.alu_out;

endmodule

`default_nettype wire

// File: mips.sv
`timescale 1ns/100ps
`default_nettype none

module mips import mips_isa_pkg::*, mips_pipe_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  output wire word_t pc,
  input  wire word_t instr,
  output wire        mem_write,
  output wire word_t mem_addr,
  output wire word_t mem_wdata,
  input  wire word_t mem_rdata
);

  opcode_t   op;
  funct_t    funct;
  ex_ctrl_t  ex_ctrl;
  mem_ctrl_t mem_ctrl;
  wb_ctrl_t  wb_ctrl;
  fwd_t      fwd;
  reg_addr_t id_rs;
  reg_addr_t id_rt;
  reg_addr_t ex_rs;
  reg_addr_t ex_rt;
  reg_addr_t ex_write_reg;
  reg_addr_t mem_write_reg;
  reg_addr_t wb_write_reg;
  logic      ex_mem_read;
  logic      mem_reg_write;
  logic      wb_reg_write;
  logic      branch_taken;
  logic      stall;
  logic      flush_if_id;
  logic      flush_id_ex;

  mips_control i_control (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_id_ex   (flush_id_ex),
    .op            (op),            // Decode stage fields
    .funct         (funct),
    .ex_ctrl       (ex_ctrl),
    .mem_ctrl      (mem_ctrl),
    .wb_ctrl       (wb_ctrl),
    .ex_mem_read   (ex_mem_read),
    .mem_reg_write (mem_reg_write),
    .wb_reg_write  (wb_reg_write)
  );

  hazard_unit i_hazard (
    .id_rs         (id_rs),
    .id_rt         (id_rt),
    .ex_rs         (ex_rs),
    .ex_rt         (ex_rt),
    .ex_write_reg  (ex_write_reg),
    .mem_write_reg (mem_write_reg),
    .wb_write_reg  (wb_write_reg),
    .ex_mem_read   (ex_mem_read),
    .mem_reg_write (mem_reg_write),
    .wb_reg_write  (wb_reg_write),
    .branch_taken  (branch_taken),
    .fwd           (fwd),
    .stall         (stall),
    .flush_if_id   (flush_if_id),
    .flush_id_ex   (flush_id_ex)
  );

  mips_datapath i_datapath (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall         (stall),
    .flush_if_id   (flush_if_id),
    .ex_ctrl       (ex_ctrl),
    .mem_ctrl      (mem_ctrl),
    .wb_ctrl       (wb_ctrl),
    .fwd           (fwd),
    .op            (op),
    .funct         (funct),
    .id_rs         (id_rs),
    .id_rt         (id_rt),
    .ex_rs         (ex_rs),
    .ex_rt         (ex_rt),
    .ex_write_reg  (ex_write_reg),
    .mem_write_reg (mem_write_reg),
    .wb_write_reg  (wb_write_reg),
    .branch_taken  (branch_taken),
    .pc            (pc),
    .instr         (instr),
    .mem_write     (mem_write),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_rdata     (mem_rdata)
  );

endmodule

`default_nettype wire

// File: tb_mips.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_cfg.svh"

module tb_mips import mips_isa_pkg::*; ();

  localparam int NROWS          = 8;
  localparam int NSTORES        = 8;
  localparam int PROG_LEN       = 29;            // Instructions in program.hex
  localparam int MEM_WORDS      = 64;
  localparam int RESET_CYCLES   = 8;
  localparam int DRAIN_CYCLES   = 4;             // Pipeline depth behind fetch
  localparam int TIMEOUT_CYCLES = NROWS * PROG_LEN * 2;
  localparam word_t HALT_PC     = 32'h0000_0070; // Self loop at word 28

  typedef struct packed {
    word_t addr;
    word_t data;
  } store_t;

  typedef struct packed {
    word_t                a;
    word_t                b;
    store_t [NSTORES-1:0] exp;
  } row_t;

  logic        clk;
  logic        rst_n = 1'b0;
  word_t       pc;
  word_t       instr;
  logic        mem_write;
  word_t       mem_addr;
  word_t       mem_wdata;
  word_t       mem_rdata;
  word_t       imem [MEM_WORDS];
  word_t       dmem [MEM_WORDS];
  word_t       row_a = '0;      // Operands placed in data words 0 and 1
  word_t       row_b = '0;
  row_t        rows [NROWS];
  string       names [NROWS];
  store_t      stores [$];
  logic        rst_seen = 1'b1;
  int          seed = 19;
  int unsigned cycles = 0;

  mips i_mips (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc        (pc),
    .instr     (instr),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //--------------------------------------------------------------------------
  // Memory models

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = '0;   // Nop past the end of the program
    end
    $readmemh("program.hex", imem);
  end

  assign instr     = imem[pc[7:2]];
  assign mem_rdata = dmem[mem_addr[7:2]];

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 2; i < MEM_WORDS; i++) begin
        dmem[i] <= 32'hd0d0_0000 | 32'(i);
      end
      dmem[0] <= row_a;
      dmem[1] <= row_b;
    end else if (mem_write) begin
      dmem[mem_addr[7:2]] <= mem_wdata;
    end
  end

  // Store log is cleared while the core is held in reset
  always @(posedge clk) begin
    if (!rst_seen) begin
      assert (!mem_write) else begin
        $display("mem_write strobe seen while the core was in reset");
        abort_run();
      end
      stores.delete();
    end else if (mem_write) begin
      stores.push_back(store_t'({mem_addr, mem_wdata}));
    end
    rst_seen <= rst_n;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the core hung", cycles);
      abort_run();
    end
  end

  //--------------------------------------------------------------------------
  // Reference model and test table

  task automatic abort_run;
    $display("Errors found");
    $fatal(1);
  endtask

  // Stores in program order
  function automatic store_t expected_store(input word_t a, input word_t b, input int k);
    store_t s;
    case (k)
      0: s = {32'd8,  a + b};
      1: s = {32'd12, a - b};
      2: s = {32'd16, a & b};
      3: s = {32'd20, a | b};
      4: s = {32'd24, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0};
      5: s = {32'd28, a + 32'd5};
      6: s = {32'd36, a + a};                           // Load-use result
      default: s = {32'd32, (a == b) ? 32'd1 : 32'd2};  // Branch outcome
    endcase
    return s;
  endfunction

  task automatic build_table;
    names[0] = "zero";
    rows[0].a = 32'h0000_0000;
    rows[0].b = 32'h0000_0000;
    names[1] = "equal";
    rows[1].a = 32'h1234_5678;
    rows[1].b = 32'h1234_5678;
    names[2] = "neg_pos";
    rows[2].a = 32'hffff_fff9;
    rows[2].b = 32'h0000_0003;
    names[3] = "max_int";
    rows[3].a = 32'h7fff_ffff;
    rows[3].b = 32'h8000_0000;
    for (int r = 4; r < NROWS; r++) begin
      names[r]  = $sformatf("random_%0d", r - 4);
      rows[r].a = $random(seed);
      rows[r].b = $random(seed);
    end
    for (int r = 0; r < NROWS; r++) begin
      for (int k = 0; k < NSTORES; k++) begin
        rows[r].exp[k] = expected_store(rows[r].a, rows[r].b, k);
      end
    end
  endtask

  // Reset with the row's operands in memory, then run to the halt loop
  task automatic run_row(input int r);
    @(posedge clk);
    row_a <= rows[r].a;
    row_b <= rows[r].b;
    rst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    assert (pc == `MIPS_RESET_PC) else begin
      $display("FAIL %s reset pc: expected %h, actual %h",
               names[r], `MIPS_RESET_PC, pc);
      abort_run();
    end
    rst_n <= 1'b1;
    while (pc !== HALT_PC) @(posedge clk);
    repeat (DRAIN_CYCLES) @(posedge clk);
  endtask

  task automatic check_stores(input int r);
    store_t got;
    store_t exp;
    assert (stores.size() == NSTORES) else begin
      $display("FAIL %s store count: expected %0d, actual %0d",
               names[r], NSTORES, stores.size());
      abort_run();
    end
    for (int k = 0; k < NSTORES; k++) begin
      got = stores[k];
      exp = rows[r].exp[k];
      assert (got == exp) else begin
        $display("FAIL %s store %0d: expected [%h] = %h, actual [%h] = %h",
                 names[r], k, exp.addr, exp.data, got.addr, got.data);
        abort_run();
      end
    end
  endtask

  initial begin
    build_table();
    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
      check_stores(r);
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: program.hex
// One 32-bit instruction per line, from word address 0; A in data word 0, B in word 1
8C010000 // lw   $1, 0($0)
00214820 // add  $9, $1, $1     load-use stall
8C020004 // lw   $2, 4($0)
00221820 // add  $3, $1, $2     load-use stall
00222022 // sub  $4, $1, $2
AC030008 // sw   $3, 8($0)      writeback forward
AC04000C // sw   $4, 12($0)
00222824 // and  $5, $1, $2
AC050010 // sw   $5, 16($0)     memory forward
00223025 // or   $6, $1, $2
0022382A // slt  $7, $1, $2
AC060014 // sw   $6, 20($0)
AC070018 // sw   $7, 24($0)
20080BAD // addi $8, $0, 0x0bad older write to $8
20280005 // addi $8, $1, 5
AC08001C // sw   $8, 28($0)     memory stage must win
AC090024 // sw   $9, 36($0)
240A0DEF // addiu $10, $0, 0x0def marker value
10220007 // beq  $1, $2, eq
14220002 // bne  $1, $2, ne
AC0A0028 // sw   $10, 40($0)    shadow marker
AC0A0028 // sw   $10, 40($0)    shadow marker
200B0002 // ne: addi $11, $0, 2
10000003 // beq  $0, $0, done
AC0A0028 // sw   $10, 40($0)    shadow marker
AC0A0028 // sw   $10, 40($0)    shadow marker
200B0001 // eq: addi $11, $0, 1
AC0B0020 // done: sw $11, 32($0)
1000FFFF // halt: beq $0, $0, halt

// File: tb.f
+incdir+.
mips_isa_pkg.sv
mips_pipe_pkg.sv
mips_control.sv
hazard_unit.sv
regfile.sv
alu.sv
mips_datapath.sv
mips.sv
tb_mips.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mips
FILELIST  = tb.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
